// File: hdl/cpu_pkg.sv
// cpu_pkg
// widths, register types, opcode constants and enums shared by the rv32 core
`default_nettype none

package cpu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [31:0]     inst_t;
    typedef logic [7:0]      apb_addr_t;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [6:0] F7_MULDIV = 7'b0000001;  // M extension

    localparam apb_addr_t DBG_INSTRET_ADDR = 8'h80;  // retired count, above x31

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // lui
    } alu_op_e;

    typedef enum logic [1:0] {UNIT_NONE, UNIT_ALU, UNIT_MULDIV} unit_e;

    typedef enum logic [1:0] {MUL_IDLE, MUL_RUN, MUL_DONE} mul_state_e;

endpackage

`default_nettype wire

// File: hdl/idu.sv
// idu
// combinational decode of the kept rv32 subset into operands, alu op and target unit
`timescale 1ns/1ps
`default_nettype none

module idu (
    input  wire cpu_pkg::inst_t  inst_i,
    output cpu_pkg::reg_addr_t   rs1_o,
    output cpu_pkg::reg_addr_t   rs2_o,
    output cpu_pkg::reg_addr_t   rd_o,
    output cpu_pkg::xlen_t       imm_o,
    output logic                 use_imm_o,
    output cpu_pkg::alu_op_e     alu_op_o,
    output cpu_pkg::unit_e       unit_o,
    output logic                 rd_we_o,
    output logic                 rs1_used_o,
    output logic                 rs2_used_o,
    output logic                 mul_high_o
);
    import cpu_pkg::*;

    localparam logic [6:0] F7_ALT = 7'b0100000;  // sub / sra

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_e    base_op;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd_o   = inst_i[11:7];
    assign rs1_o  = inst_i[19:15];
    assign rs2_o  = inst_i[24:20];

    always_comb begin
        case (funct3)
            3'b000:  base_op = ALU_ADD;
            3'b001:  base_op = ALU_SLL;
            3'b010:  base_op = ALU_SLT;
            3'b011:  base_op = ALU_SLTU;
            3'b100:  base_op = ALU_XOR;
            3'b101:  base_op = ALU_SRL;
            3'b110:  base_op = ALU_OR;
            default: base_op = ALU_AND;
        endcase
    end

    always_comb begin
        unit_o     = UNIT_NONE;
        alu_op_o   = base_op;
        use_imm_o  = 1'b0;
        imm_o      = {{20{inst_i[31]}}, inst_i[31:20]};  // I-type
        rs1_used_o = 1'b0;
        rs2_used_o = 1'b0;
        mul_high_o = 1'b0;
        case (opcode)
            OPC_LUI: begin
                unit_o    = UNIT_ALU;
                alu_op_o  = ALU_PASS_B;
                use_imm_o = 1'b1;
                imm_o     = {inst_i[31:12], 12'b0};
            end
            OPC_OP_IMM: begin
                use_imm_o  = 1'b1;
                rs1_used_o = 1'b1;
                if (funct3 == 3'b101 && funct7 == F7_ALT) begin
                    unit_o   = UNIT_ALU;
                    alu_op_o = ALU_SRA;
                end else if (funct3[1:0] != 2'b01 || funct7 == 7'b0) begin
                    unit_o = UNIT_ALU;  // shifts need a clean funct7
                end
            end
            OPC_OP: begin
                rs1_used_o = 1'b1;
                rs2_used_o = 1'b1;
                if (funct7 == 7'b0) begin
                    unit_o = UNIT_ALU;
                end else if (funct7 == F7_ALT && funct3 == 3'b000) begin
                    unit_o   = UNIT_ALU;
                    alu_op_o = ALU_SUB;
                end else if (funct7 == F7_ALT && funct3 == 3'b101) begin
                    unit_o   = UNIT_ALU;
                    alu_op_o = ALU_SRA;
                end else if (funct7 == F7_MULDIV && (funct3 == 3'b000 || funct3 == 3'b011)) begin
                    unit_o     = UNIT_MULDIV;
                    mul_high_o = funct3[1];  // mulhu
                end
            end
            default: ;
        endcase
    end

    assign rd_we_o = (unit_o != UNIT_NONE);

endmodule

`default_nettype wire

// File: hdl/hdu.sv
// hdu
// scoreboard for the single outstanding multiply that holds back conflicting instructions
`timescale 1ns/1ps
`default_nettype none

module hdu (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  wire                     inst_valid_i,
    input  wire cpu_pkg::unit_e     unit_i,
    input  wire cpu_pkg::reg_addr_t rs1_i,
    input  wire cpu_pkg::reg_addr_t rs2_i,
    input  wire cpu_pkg::reg_addr_t rd_i,
    input  wire                     rs1_used_i,
    input  wire                     rs2_used_i,
    input  wire                     rd_we_i,
    input  wire                     mul_commit_i,
    output logic                    inst_ready_o,
    output logic                    issue_o
);
    import cpu_pkg::*;

    logic      busy_q;
    reg_addr_t busy_rd_q;  // rd of the multiply in flight
    logic      rd_hazard;

    assign rd_hazard = (rs1_used_i && rs1_i == busy_rd_q)
                     | (rs2_used_i && rs2_i == busy_rd_q)
                     | (rd_we_i && rd_i == busy_rd_q);

    assign inst_ready_o = !(busy_q && (rd_hazard || unit_i == UNIT_MULDIV));
    assign issue_o      = inst_valid_i && inst_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else if (issue_o && unit_i == UNIT_MULDIV) begin
            busy_q <= 1'b1;
        end else if (mul_commit_i) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_o && unit_i == UNIT_MULDIV) busy_rd_q <= rd_i;
    end

    // wbu may only commit the multiply this scoreboard let through
    a_commit_while_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mul_commit_i |-> busy_q)
        else $error("multiply committed while none was outstanding");

endmodule

`default_nettype wire

// File: hdl/gpr.sv
// gpr
// 32 x 32 register file, write-through on the operand ports, debug read port
`timescale 1ns/1ps
`default_nettype none

module gpr (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  wire                     we_i,
    input  wire cpu_pkg::reg_addr_t waddr_i,
    input  wire cpu_pkg::xlen_t     wdata_i,
    input  wire cpu_pkg::reg_addr_t raddr1_i,
    input  wire cpu_pkg::reg_addr_t raddr2_i,
    input  wire cpu_pkg::reg_addr_t dbg_raddr_i,
    output cpu_pkg::xlen_t          rdata1_o,
    output cpu_pkg::xlen_t          rdata2_o,
    output cpu_pkg::xlen_t          dbg_rdata_o
);
    import cpu_pkg::*;

    xlen_t regs_q [32];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) regs_q[i] <= '0;
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // bypass the write of this cycle, x0 stays zero
    assign rdata1_o = (we_i && raddr1_i == waddr_i && raddr1_i != '0) ? wdata_i
                                                                      : regs_q[raddr1_i];
    assign rdata2_o = (we_i && raddr2_i == waddr_i && raddr2_i != '0) ? wdata_i
                                                                      : regs_q[raddr2_i];
    assign dbg_rdata_o = regs_q[dbg_raddr_i];

    // wbu drops commits to x0 before they reach the port
    a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        we_i |-> waddr_i != '0)
        else $error("write enable raised for x0");

endmodule

`default_nettype wire

// File: hdl/exu_alu.sv
// exu_alu
// single-cycle alu, result and destination held one cycle for write-back
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  wire                     issue_i,
    input  wire cpu_pkg::unit_e     unit_i,
    input  wire cpu_pkg::alu_op_e   alu_op_i,
    input  wire cpu_pkg::xlen_t     op1_i,
    input  wire cpu_pkg::xlen_t     rs2_data_i,
    input  wire cpu_pkg::xlen_t     imm_i,
    input  wire                     use_imm_i,
    input  wire cpu_pkg::reg_addr_t rd_i,
    input  wire                     rd_we_i,
    output logic                    wb_valid_o,
    output cpu_pkg::reg_addr_t      wb_rd_o,
    output cpu_pkg::xlen_t          wb_data_o
);
    import cpu_pkg::*;

    xlen_t      op2;
    xlen_t      result;
    logic [4:0] shamt;
    logic       take;

    assign op2   = use_imm_i ? imm_i : rs2_data_i;
    assign shamt = op2[4:0];
    assign take  = issue_i && unit_i == UNIT_ALU && rd_we_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  result = op1_i + op2;
            ALU_SUB:  result = op1_i - op2;
            ALU_SLL:  result = op1_i << shamt;
            ALU_SLT:  result = {31'b0, $signed(op1_i) < $signed(op2)};
            ALU_SLTU: result = {31'b0, op1_i < op2};
            ALU_XOR:  result = op1_i ^ op2;
            ALU_SRL:  result = op1_i >> shamt;
            ALU_SRA:  result = xlen_t'($signed(op1_i) >>> shamt);
            ALU_OR:   result = op1_i | op2;
            ALU_AND:  result = op1_i & op2;
            default:  result = op2;  // pass b for lui
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) wb_valid_o <= 1'b0;
        else          wb_valid_o <= take;
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            wb_rd_o   <= rd_i;
            wb_data_o <= result;
        end
    end

endmodule

`default_nettype wire

// File: hdl/exu_muldiv.sv
// exu_muldiv
// unsigned shift-add multiplier, 32 iterations, result held until write-back takes it
`timescale 1ns/1ps
`default_nettype none

module exu_muldiv (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  wire                     issue_i,
    input  wire cpu_pkg::unit_e     unit_i,
    input  wire cpu_pkg::xlen_t     op1_i,
    input  wire cpu_pkg::xlen_t     op2_i,
    input  wire cpu_pkg::reg_addr_t rd_i,
    input  wire                     high_i,
    input  wire                     mul_ready_i,
    output logic                    mul_valid_o,
    output cpu_pkg::reg_addr_t      mul_rd_o,
    output cpu_pkg::xlen_t          mul_data_o
);
    import cpu_pkg::*;

    mul_state_e  state_q;
    logic [4:0]  iter_q;
    logic        start;
    xlen_t       mcand_q;
    logic [63:0] prod_q;    // upper half accumulates, lower half shifts out the multiplier
    logic        high_q;
    logic [32:0] psum;

    assign start = issue_i && unit_i == UNIT_MULDIV;
    assign psum  = {1'b0, prod_q[63:32]} + (prod_q[0] ? {1'b0, mcand_q} : 33'b0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= MUL_IDLE;
            iter_q  <= '0;
        end else begin
            case (state_q)
                MUL_IDLE: if (start) begin
                    state_q <= MUL_RUN;
                    iter_q  <= '0;
                end
                MUL_RUN: begin
                    iter_q <= iter_q + 5'd1;
                    if (iter_q == 5'd31) state_q <= MUL_DONE;
                end
                MUL_DONE: if (mul_ready_i) state_q <= MUL_IDLE;
                default:  state_q <= MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == MUL_IDLE && start) begin
            mcand_q  <= op1_i;
            prod_q   <= {32'b0, op2_i};
            mul_rd_o <= rd_i;
            high_q   <= high_i;
        end else if (state_q == MUL_RUN) begin
            prod_q <= {psum, prod_q[31:1]};
        end
    end

    assign mul_valid_o = (state_q == MUL_DONE);
    assign mul_data_o  = high_q ? prod_q[63:32] : prod_q[31:0];

endmodule

`default_nettype wire

// File: hdl/wbu.sv
// wbu
// write-back arbiter, alu first, multiply waits, one retire pulse per commit
`timescale 1ns/1ps
`default_nettype none

module wbu (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  wire                     alu_valid_i,
    input  wire cpu_pkg::reg_addr_t alu_rd_i,
    input  wire cpu_pkg::xlen_t     alu_data_i,
    input  wire                     mul_valid_i,
    input  wire cpu_pkg::reg_addr_t mul_rd_i,
    input  wire cpu_pkg::xlen_t     mul_data_i,
    output logic                    mul_ready_o,
    output logic                    mul_commit_o,
    output logic                    we_o,
    output cpu_pkg::reg_addr_t      waddr_o,
    output cpu_pkg::xlen_t          wdata_o,
    output logic                    retire_o
);
    assign mul_ready_o  = !alu_valid_i;
    assign mul_commit_o = mul_valid_i && mul_ready_o;

    assign waddr_o  = alu_valid_i ? alu_rd_i : mul_rd_i;
    assign wdata_o  = alu_valid_i ? alu_data_i : mul_data_i;
    assign retire_o = alu_valid_i || mul_commit_o;  // x0 results still retire
    assign we_o     = retire_o && waddr_o != '0;

    // muldiv result must not move while the alu holds the port
    a_mul_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (mul_valid_i && !mul_ready_o) |=>
            (mul_valid_i && $stable(mul_rd_i) && $stable(mul_data_i)))
        else $error("stalled multiply result changed before commit");

endmodule

`default_nettype wire

// File: hdl/dbg_apb.sv
// dbg_apb
// read-only apb debug window, x0..x31 at 0x00-0x7c and the retired count at 0x80
`timescale 1ns/1ps
`default_nettype none

module dbg_apb #(
    parameter int INSTRET_WIDTH = 32
) (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  wire                     psel_i,
    input  wire                     penable_i,
    input  wire                     pwrite_i,
    input  wire cpu_pkg::apb_addr_t paddr_i,
    input  wire                     retire_i,
    input  wire cpu_pkg::xlen_t     dbg_rdata_i,
    output cpu_pkg::reg_addr_t      dbg_raddr_o,
    output cpu_pkg::xlen_t          prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o
);
    import cpu_pkg::*;

    logic [INSTRET_WIDTH-1:0] instret_q;
    logic                     access;
    logic                     hit_reg;
    logic                     hit_cnt;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i)      instret_q <= '0;
        else if (retire_i) instret_q <= instret_q + 1'b1;
    end

    assign access  = psel_i && penable_i;
    assign hit_reg = !paddr_i[7] && paddr_i[1:0] == 2'b00;  // word aligned gpr window
    assign hit_cnt = (paddr_i == DBG_INSTRET_ADDR);

    assign dbg_raddr_o = paddr_i[6:2];
    assign prdata_o    = hit_reg ? dbg_rdata_i
                       : hit_cnt ? XLEN'(instret_q)
                       : '0;
    assign pready_o    = access;  // no wait states
    assign pslverr_o   = access && (pwrite_i || !(hit_reg || hit_cnt));

endmodule

`default_nettype wire

// File: hdl/cpu_top.sv
// cpu_top
// rv32 integer execution core with alu, iterative multiply and write-back,
// fed through a valid/ready instruction port, apb debug readback on the side
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter int INSTRET_WIDTH = 32
) (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  wire                     inst_valid_i,
    input  wire cpu_pkg::inst_t     inst_i,
    output logic                    inst_ready_o,
    input  wire                     psel_i,
    input  wire                     penable_i,
    input  wire                     pwrite_i,
    input  wire cpu_pkg::apb_addr_t paddr_i,
    input  wire cpu_pkg::xlen_t     pwdata_i,  // debug port is read only
    output cpu_pkg::xlen_t          prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o
);
    import cpu_pkg::*;

    reg_addr_t idu_rs1, idu_rs2, idu_rd;
    xlen_t     idu_imm;
    alu_op_e   idu_alu_op;
    unit_e     idu_unit;
    logic      idu_use_imm, idu_rd_we, idu_rs1_used, idu_rs2_used, idu_mul_high;

    logic      issue;
    xlen_t     rs1_data, rs2_data;
    reg_addr_t dbg_raddr;
    xlen_t     dbg_rdata;

    logic      alu_wb_valid;
    reg_addr_t alu_wb_rd;
    xlen_t     alu_wb_data;

    logic      mul_valid, mul_ready, mul_commit;
    reg_addr_t mul_rd;
    xlen_t     mul_data;

    logic      wb_we, retire;
    reg_addr_t wb_waddr;
    xlen_t     wb_wdata;

    idu u_idu (
        .inst_i    (inst_i),
        .rs1_o     (idu_rs1),
        .rs2_o     (idu_rs2),
        .rd_o      (idu_rd),
        .imm_o     (idu_imm),
        .use_imm_o (idu_use_imm),
        .alu_op_o  (idu_alu_op),
        .unit_o    (idu_unit),
        .rd_we_o   (idu_rd_we),
        .rs1_used_o(idu_rs1_used),
        .rs2_used_o(idu_rs2_used),
        .mul_high_o(idu_mul_high)
    );

    hdu u_hdu (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .inst_valid_i(inst_valid_i),
        .unit_i      (idu_unit),
        .rs1_i       (idu_rs1),
        .rs2_i       (idu_rs2),
        .rd_i        (idu_rd),
        .rs1_used_i  (idu_rs1_used),
        .rs2_used_i  (idu_rs2_used),
        .rd_we_i     (idu_rd_we),
        .mul_commit_i(mul_commit),
        .inst_ready_o(inst_ready_o),
        .issue_o     (issue)
    );

    gpr u_gpr (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .we_i       (wb_we),
        .waddr_i    (wb_waddr),
        .wdata_i    (wb_wdata),
        .raddr1_i   (idu_rs1),
        .raddr2_i   (idu_rs2),
        .dbg_raddr_i(dbg_raddr),
        .rdata1_o   (rs1_data),
        .rdata2_o   (rs2_data),
        .dbg_rdata_o(dbg_rdata)
    );

    exu_alu u_exu_alu (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .issue_i   (issue),
        .unit_i    (idu_unit),
        .alu_op_i  (idu_alu_op),
        .op1_i     (rs1_data),
        .rs2_data_i(rs2_data),
        .imm_i     (idu_imm),
        .use_imm_i (idu_use_imm),
        .rd_i      (idu_rd),
        .rd_we_i   (idu_rd_we),
        .wb_valid_o(alu_wb_valid),
        .wb_rd_o   (alu_wb_rd),
        .wb_data_o (alu_wb_data)
    );

    exu_muldiv u_exu_muldiv (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .issue_i    (issue),
        .unit_i     (idu_unit),
        .op1_i      (rs1_data),
        .op2_i      (rs2_data),
        .rd_i       (idu_rd),
        .high_i     (idu_mul_high),
        .mul_ready_i(mul_ready),
        .mul_valid_o(mul_valid),
        .mul_rd_o   (mul_rd),
        .mul_data_o (mul_data)
    );

    wbu u_wbu (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .alu_valid_i (alu_wb_valid),
        .alu_rd_i    (alu_wb_rd),
        .alu_data_i  (alu_wb_data),
        .mul_valid_i (mul_valid),
        .mul_rd_i    (mul_rd),
        .mul_data_i  (mul_data),
        .mul_ready_o (mul_ready),
        .mul_commit_o(mul_commit),
        .we_o        (wb_we),
        .waddr_o     (wb_waddr),
        .wdata_o     (wb_wdata),
        .retire_o    (retire)
    );

    dbg_apb #(
        .INSTRET_WIDTH(INSTRET_WIDTH)
    ) u_dbg_apb (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .retire_i   (retire),
        .dbg_rdata_i(dbg_rdata),
        .dbg_raddr_o(dbg_raddr),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o)
    );

endmodule

`default_nettype wire

// File: testbench/tb_cpu_model.svh
// reference model of the kept rv32 subset, executed in program order
// plus instruction encoders and random instruction generators
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

logic [31:0] model_regs [32];
int unsigned model_retired;

function automatic logic [31:0] next_random();
    return $random(seed);  // seed lives in the testbench module
endfunction

function automatic inst_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic inst_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                reg_addr_t rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
endfunction

function automatic inst_t enc_u(logic [19:0] imm, reg_addr_t rd);
    return {imm, rd, OPC_LUI};
endfunction

function automatic void model_exec(inst_t word);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [63:0] prod;
    logic        ok;
    opc = word[6:0];
    f3  = word[14:12];
    f7  = word[31:25];
    a   = model_regs[word[19:15]];
    b   = (opc == OPC_OP) ? model_regs[word[24:20]] : {{20{word[31]}}, word[31:20]};
    ok  = 1'b0;
    res = '0;
    if (opc == OPC_LUI) begin
        ok  = 1'b1;
        res = {word[31:12], 12'b0};
    end else if (opc == OPC_OP && f7 == 7'b0000001) begin
        prod = {32'b0, a} * {32'b0, b};  // unsigned product
        ok   = (f3 == 3'b000 || f3 == 3'b011);
        res  = (f3 == 3'b011) ? prod[63:32] : prod[31:0];
    end else if (opc == OPC_OP || opc == OPC_OP_IMM) begin
        ok = 1'b1;
        case (f3)
            3'b000:  res = (opc == OPC_OP && f7 == 7'b0100000) ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  res = (a < b) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b101:  res = (f7 == 7'b0100000) ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        // funct7 legality for register ops and immediate shifts
        if (opc == OPC_OP && f7 != 7'b0 && !(f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101)))
            ok = 1'b0;
        if (opc == OPC_OP_IMM && f3 == 3'b001 && f7 != 7'b0)
            ok = 1'b0;
        if (opc == OPC_OP_IMM && f3 == 3'b101 && f7 != 7'b0 && f7 != 7'b0100000)
            ok = 1'b0;
    end
    if (ok) begin
        model_retired++;
        if (word[11:7] != 5'd0) model_regs[word[11:7]] = res;
    end
endfunction

// one kept instruction on x0..x7
function automatic inst_t gen_kept();
    logic [31:0] r;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [31:0] k;
    r   = next_random();
    rd  = {2'b0, r[2:0]};
    rs1 = {2'b0, r[5:3]};
    rs2 = {2'b0, r[8:6]};
    k   = next_random() % 22;
    r   = next_random();
    if (k < 8) return enc_r(7'b0, rs2, rs1, k[2:0], rd);
    case (k)
        8:       return enc_r(7'b0100000, rs2, rs1, 3'b000, rd);  // sub
        9:       return enc_r(7'b0100000, rs2, rs1, 3'b101, rd);  // sra
        10:      return enc_i(r[11:0], rs1, 3'b000, rd);
        11:      return enc_i(r[11:0], rs1, 3'b010, rd);
        12:      return enc_i(r[11:0], rs1, 3'b011, rd);
        13:      return enc_i(r[11:0], rs1, 3'b100, rd);
        14:      return enc_i(r[11:0], rs1, 3'b110, rd);
        15:      return enc_i(r[11:0], rs1, 3'b111, rd);
        16:      return enc_i({7'b0, r[4:0]}, rs1, 3'b001, rd);
        17:      return enc_i({7'b0, r[4:0]}, rs1, 3'b101, rd);
        18:      return enc_i({7'b0100000, r[4:0]}, rs1, 3'b101, rd);
        19:      return enc_u(r[19:0], rd);
        20:      return enc_r(7'b0000001, rs2, rs1, 3'b000, rd);  // mul
        default: return enc_r(7'b0000001, rs2, rs1, 3'b011, rd);  // mulhu
    endcase
endfunction

// dropped encodings: loads, stores, branches, other M ops
function automatic inst_t gen_unsupported();
    logic [31:0] r;
    logic [2:0]  f3;
    r  = next_random();
    f3 = (r[14:12] == 3'b000 || r[14:12] == 3'b011) ? 3'b100 : r[14:12];
    case (next_random() % 4)
        0:       return {r[31:7], 7'b0000011};
        1:       return {r[31:7], 7'b0100011};
        2:       return {r[31:7], 7'b1100011};
        default: return {7'b0000001, r[24:15], f3, r[11:7], OPC_OP};
    endcase
endfunction

`endif

// File: testbench/tb_cpu_top.sv
// tb_cpu_top
// directed and random programs for the rv32 core, checked through the apb debug port
// against an in-order reference model
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;
    import cpu_pkg::*;

    localparam int N_CHAIN        = 20;
    localparam int N_MUL          = 12;
    localparam int N_RAND         = 300;
    localparam int N_MIX          = 100;
    localparam int N_UNSUP        = 20;
    localparam int TOTAL_INST     = N_CHAIN + N_MUL + N_RAND + N_MIX + N_UNSUP;
    localparam int TIMEOUT_CYCLES = TOTAL_INST * 36 + 500;

    integer seed = 66;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      inst_valid;
    inst_t     inst;
    logic      inst_ready;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    xlen_t     pwdata;
    xlen_t     prdata;
    logic      pready;
    logic      pslverr;

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int cycles       = 0;
    int stall_cycles = 0;

`include "tb_cpu_model.svh"

    cpu_top #(
        .INSTRET_WIDTH(32)
    ) dut0 (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .inst_valid_i(inst_valid),
        .inst_i      (inst),
        .inst_ready_o(inst_ready),
        .psel_i      (psel),
        .penable_i   (penable),
        .pwrite_i    (pwrite),
        .paddr_i     (paddr),
        .pwdata_i    (pwdata),
        .prdata_o    (prdata),
        .pready_o    (pready),
        .pslverr_o   (pslverr)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cycles <= cycles + 1;

    initial begin
        while (cycles < TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
            errors++;
        end
    endtask

    // present one instruction from the falling edge until the core takes it
    task automatic send_inst(input inst_t word);
        @(negedge clk);
        inst_valid = 1'b1;
        inst       = word;
        #1;
        while (!inst_ready) begin
            stall_cycles++;
            @(negedge clk);
            #1;
        end
        model_exec(word);  // accepted at the coming rising edge
    endtask

    task automatic idle(input int n);
        @(negedge clk);
        inst_valid = 1'b0;
        repeat (n - 1) @(negedge clk);
    endtask

    task automatic apb_access(input logic write, input apb_addr_t addr, input xlen_t wdata,
                              output xlen_t rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        assert (pready) else begin
            $display("APB access to %02h had pready low in the access phase", addr);
            errors++;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // all registers and the retired count against the model
    task automatic compare_state();
        xlen_t data;
        logic  err;
        for (int i = 0; i < 32; i++) begin
            apb_access(1'b0, apb_addr_t'(i * 4), '0, data, err);
            check_value($sformatf("x%0d", i), data, model_regs[i]);
            check_value($sformatf("pslverr on x%0d", i), {31'b0, err}, 32'd0);
        end
        apb_access(1'b0, DBG_INSTRET_ADDR, '0, data, err);
        check_value("retired count", data, model_retired);
        check_value("pslverr on retired count", {31'b0, err}, 32'd0);
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %-12s ok", name);
        end else begin
            tests_failed++;
            $display("test %-12s failed with %0d errors", name, errors - errs_before);
        end
    endtask

    // every instruction reads the rd of the one before it
    task automatic run_chain();
        send_inst(enc_u(20'h80001, 1));
        send_inst(enc_i(12'h765, 1, 3'b000, 2));
        send_inst(enc_r(7'b0, 1, 2, 3'b000, 3));
        send_inst(enc_r(7'b0100000, 1, 3, 3'b000, 4));
        send_inst(enc_r(7'b0, 2, 4, 3'b001, 5));
        send_inst(enc_r(7'b0, 4, 5, 3'b010, 6));
        send_inst(enc_r(7'b0, 4, 6, 3'b011, 7));
        send_inst(enc_r(7'b0, 3, 7, 3'b100, 1));
        send_inst(enc_r(7'b0, 2, 1, 3'b101, 2));
        send_inst(enc_r(7'b0100000, 5, 2, 3'b101, 3));
        send_inst(enc_r(7'b0, 1, 3, 3'b110, 4));
        send_inst(enc_r(7'b0, 3, 4, 3'b111, 5));
        send_inst(enc_i(12'hfff, 5, 3'b010, 6));
        send_inst(enc_i(12'h001, 6, 3'b011, 7));
        send_inst(enc_i(12'ha5a, 7, 3'b100, 1));
        send_inst(enc_i(12'h0f0, 1, 3'b110, 2));
        send_inst(enc_i(12'h7ff, 2, 3'b111, 3));
        send_inst(enc_i(12'h007, 3, 3'b001, 4));
        send_inst(enc_i(12'h003, 4, 3'b101, 5));
        send_inst(enc_i({7'b0100000, 5'd9}, 5, 3'b101, 6));
    endtask

    task automatic run_mul();
        send_inst(enc_i(12'hff9, 0, 3'b000, 1));          // x1 = -7
        send_inst(enc_u(20'h12345, 2));
        send_inst(enc_i(12'h678, 2, 3'b000, 2));
        send_inst(enc_r(7'b0000001, 2, 1, 3'b000, 3));    // mul
        send_inst(enc_r(7'b0, 1, 3, 3'b000, 4));          // needs x3, must wait
        send_inst(enc_i(12'h00b, 0, 3'b000, 5));
        send_inst(enc_r(7'b0, 2, 5, 3'b100, 6));
        send_inst(enc_r(7'b0000001, 2, 1, 3'b011, 7));    // mulhu
        send_inst(enc_i(12'h055, 5, 3'b110, 5));          // independent, flows past it
        send_inst(enc_r(7'b0, 5, 6, 3'b111, 6));
        send_inst(enc_r(7'b0100000, 2, 7, 3'b000, 1));    // consumer of x7
        send_inst(enc_r(7'b0000001, 1, 1, 3'b011, 0));    // retires without a write
    endtask

    initial begin
        int    mark;
        xlen_t data;
        logic  err;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        model_retired = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        mark = errors;
        check_value("inst_ready after reset", {31'b0, inst_ready}, 32'd1);
        compare_state();
        end_test("reset", mark);

        mark = errors;
        run_chain();
        idle(50);
        compare_state();
        end_test("alu_chain", mark);

        mark = errors;
        stall_cycles = 0;
        run_mul();
        idle(50);
        assert (stall_cycles > 0) else begin
            $display("inst_ready never dropped for an instruction that needs a multiply result");
            errors++;
        end
        compare_state();
        end_test("multiply", mark);

        mark = errors;
        for (int n = 0; n < N_RAND; n++) begin
            send_inst(gen_kept());
            if (next_random() % 4 == 0) idle(1 + int'(next_random() % 3));
        end
        idle(50);
        compare_state();
        end_test("random", mark);

        mark = errors;
        repeat (N_UNSUP) send_inst(gen_unsupported());
        for (int n = 0; n < N_MIX; n++) begin
            if (next_random() % 3 == 0) send_inst(gen_unsupported());
            else                        send_inst(gen_kept());
        end
        idle(50);
        compare_state();
        end_test("unsupported", mark);

        mark = errors;
        apb_access(1'b1, 8'h04, 32'hdeadbeef, data, err);
        check_value("pslverr on apb write", {31'b0, err}, 32'd1);
        apb_access(1'b0, 8'h84, '0, data, err);
        check_value("pslverr on read of 0x84", {31'b0, err}, 32'd1);
        compare_state();
        end_test("apb_errors", mark);

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cpu_top.f
+incdir+testbench
hdl/cpu_pkg.sv
hdl/idu.sv
hdl/hdu.sv
hdl/gpr.sv
hdl/exu_alu.sv
hdl/exu_muldiv.sv
hdl/wbu.sv
hdl/dbg_apb.sv
hdl/cpu_top.sv
testbench/tb_cpu_top.sv

// File: Makefile
# verilator build and run of the cpu_top testbench

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_top \
		-f cpu_top.f --Mdir obj_dir -o tb_cpu_top
	./obj_dir/tb_cpu_top > sim.log 2>&1; cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log || ! grep -q "TEST RESULT: PASS" sim.log; \
		then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
